// File: Makefile
# Verilator build for the convolution engine testbench.

VERILATOR ?= verilator
TOP       ?= tb_conv_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard *.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: conv_pkg.sv
package conv_pkg;

    // Kernel geometry.
    localparam int KERNEL_DIM = 3;
    localparam int NUM_TAPS   = KERNEL_DIM * KERNEL_DIM;

    localparam int PIXEL_W   = 8;
    localparam int WEIGHT_W  = 8;
    localparam int TAP_IDX_W = 4;
    localparam int PSUM_W    = 18;  // Three 17-bit products.
    localparam int OFMAP_W   = 20;

    // Unsigned ifmap pixel.
    typedef logic [PIXEL_W-1:0] pixel_t;

    // Signed kernel weight.
    typedef logic signed [WEIGHT_W-1:0] weight_t;

    // Row * 3 + column.
    typedef logic [TAP_IDX_W-1:0] tap_idx_t;

    // Sum of one kernel row.
    typedef logic signed [PSUM_W-1:0] psum_t;

    typedef logic signed [OFMAP_W-1:0] ofmap_t;

    typedef enum logic {
        STRIDE_1,
        STRIDE_2
    } stride_mode_t;

    // Position of the window within the current ifmap row.
    typedef enum logic [1:0] {
        ROW_IDLE,
        ROW_FILL,
        ROW_RUN
    } row_state_t;

endpackage

// File: conv_top.sv
`timescale 1ns/1ps

module conv_top import conv_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      weight_en,
    input  tap_idx_t                  weight_idx,
    input  weight_t                   weight_data,
    input  stride_mode_t              stride_sel,
    input  logic                      col_valid,
    input  logic                      row_first,
    input  pixel_t [KERNEL_DIM-1:0]   col_pixels,
    output logic                      ofmap_valid,
    output ofmap_t                    ofmap
);

    logic                                    fire;
    pixel_t [KERNEL_DIM-1:0][KERNEL_DIM-1:0] window;
    weight_t [NUM_TAPS-1:0]                  weights;

    psum_if u_psum_if ();

    window_ctrl u_window_ctrl (
        .clk        (clk),
        .rst        (rst),
        .col_valid  (col_valid),
        .row_first  (row_first),
        .stride_sel (stride_sel),
        .fire       (fire)
    );

    window_buffer u_window_buffer (
        .clk        (clk),
        .rst        (rst),
        .col_valid  (col_valid),
        .row_first  (row_first),
        .col_pixels (col_pixels),
        .window     (window)
    );

    weight_bank u_weight_bank (
        .clk         (clk),
        .rst         (rst),
        .weight_en   (weight_en),
        .weight_idx  (weight_idx),
        .weight_data (weight_data),
        .weights     (weights)
    );

    mac_array u_mac_array (
        .clk     (clk),
        .rst     (rst),
        .fire    (fire),
        .window  (window),
        .weights (weights),
        .psums   (u_psum_if.array_side)
    );

    ofmap_sum u_ofmap_sum (
        .clk         (clk),
        .rst         (rst),
        .psums       (u_psum_if.sum_side),
        .ofmap_valid (ofmap_valid),
        .ofmap       (ofmap)
    );

    // Fixed latency from column strobe to result.
    a_latency: assert property (@(posedge clk) disable iff (rst)
        ofmap_valid |-> $past(col_valid, 3));

endmodule

// File: mac_array.sv
`timescale 1ns/1ps

module mac_array import conv_pkg::*; (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     fire,
    input  pixel_t [KERNEL_DIM-1:0][KERNEL_DIM-1:0]  window,
    input  weight_t [NUM_TAPS-1:0]                   weights,
    psum_if.array_side                               psums
);

    psum_t row_psum [KERNEL_DIM];

    // Kernel row r on PE row r.
    for (genvar r = 0; r < KERNEL_DIM; r++) begin : g_row
        pe_row u_pe_row (
            .clk     (clk),
            .pixels  (window[r]),
            .weights (weights[r*KERNEL_DIM +: KERNEL_DIM]),
            .psum    (row_psum[r])
        );
    end

    assign psums.psum0 = row_psum[0];
    assign psums.psum1 = row_psum[1];
    assign psums.psum2 = row_psum[2];

    // Valid follows the PE register stage.
    always_ff @(posedge clk) begin
        if (rst) begin
            psums.valid <= 1'b0;
        end else begin
            psums.valid <= fire;
        end
    end

endmodule

// File: ofmap_sum.sv
`timescale 1ns/1ps

module ofmap_sum import conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    psum_if.sum_side    psums,
    output logic        ofmap_valid,
    output ofmap_t      ofmap
);

    ofmap_t sum_next;

    // Sign extend each row sum to the output width.
    assign sum_next = ofmap_t'(psums.psum0) + ofmap_t'(psums.psum1)
                    + ofmap_t'(psums.psum2);

    always_ff @(posedge clk) begin
        if (rst) begin
            ofmap_valid <= 1'b0;
        end else begin
            ofmap_valid <= psums.valid;
        end
    end

    always_ff @(posedge clk) begin
        ofmap <= sum_next;
    end

    // Back to back results need back to back row sums.
    a_valid_pair: assert property (@(posedge clk) disable iff (rst)
        (ofmap_valid && $past(ofmap_valid))
            |-> ($past(psums.valid) && $past(psums.valid, 2)));

endmodule

// File: pe_row.sv
`timescale 1ns/1ps

module pe_row import conv_pkg::*; (
    input  logic                       clk,
    input  pixel_t  [KERNEL_DIM-1:0]   pixels,
    input  weight_t [KERNEL_DIM-1:0]   weights,
    output psum_t                      psum
);

    psum_t prod [KERNEL_DIM];
    psum_t pair_sum;

    // Pixel gets a zero sign bit before the signed multiply.
    always_comb begin
        for (int i = 0; i < KERNEL_DIM; i++) begin
            prod[i] = $signed({1'b0, pixels[i]}) * $signed(weights[i]);
        end
    end

    assign pair_sum = prod[0] + prod[1];

    always_ff @(posedge clk) begin
        psum <= pair_sum + prod[2];
    end

endmodule

// File: psum_if.sv
`timescale 1ns/1ps

interface psum_if import conv_pkg::*; ();

    logic  valid;  // One cycle per window.
    psum_t psum0;  // Kernel row 0, top.
    psum_t psum1;
    psum_t psum2;

    modport array_side (
        output valid,
        output psum0,
        output psum1,
        output psum2
    );

    modport sum_side (
        input valid,
        input psum0,
        input psum1,
        input psum2
    );

endinterface

// File: tb_conv_top.sv
`timescale 1ns/1ps

module tb_conv_top import conv_pkg::*; ();

    // Row runs: stride, columns, expected results, weight load, pixel mode, gaps.
    // Weight load 0 keeps, 1 random, 2 extreme. Pixel mode 1 uses only 0 and 255.
    localparam int NUM_ROWS = 10;
    localparam int ROW_STRIDE [NUM_ROWS] = '{1, 1, 2, 2, 1, 2, 1, 2, 1, 1};
    localparam int ROW_COLS   [NUM_ROWS] = '{6, 5, 7, 8, 8, 9, 3, 4, 2, 4};
    localparam int ROW_EXP    [NUM_ROWS] = '{4, 3, 3, 3, 6, 4, 1, 1, 0, 2};
    localparam int ROW_WGT    [NUM_ROWS] = '{1, 0, 0, 1, 2, 0, 1, 0, 0, 0};
    localparam int ROW_PIX    [NUM_ROWS] = '{0, 0, 0, 0, 1, 1, 0, 0, 0, 1};
    localparam int ROW_GAP    [NUM_ROWS] = '{0, 1, 0, 1, 0, 0, 0, 0, 0, 0};

    logic                    clk;
    logic                    rst;
    logic                    weight_en;
    tap_idx_t                weight_idx;
    weight_t                 weight_data;
    stride_mode_t            stride_sel;
    logic                    col_valid;
    logic                    row_first;
    pixel_t [KERNEL_DIM-1:0] col_pixels;
    logic                    ofmap_valid;
    ofmap_t                  ofmap;

    logic [31:0] lcg_state;
    int          errors;
    int          cyc;          // Falling edges since start.
    int          cycle_limit;
    int          col_count;
    int          model_wgt [NUM_TAPS];
    int          model_win [KERNEL_DIM][KERNEL_DIM];  // [row][col], col 0 oldest.
    int          got_count [NUM_ROWS];
    int          exp_val_q [$];
    int          exp_cyc_q [$];
    int          exp_row_q [$];

    conv_top u_conv_top (
        .clk         (clk),
        .rst         (rst),
        .weight_en   (weight_en),
        .weight_idx  (weight_idx),
        .weight_data (weight_data),
        .stride_sel  (stride_sel),
        .col_valid   (col_valid),
        .row_first   (row_first),
        .col_pixels  (col_pixels),
        .ofmap_valid (ofmap_valid),
        .ofmap       (ofmap)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int pick_pixel(input int mode);
        logic [31:0] rnd;
        rnd = lcg_next();
        if (mode == 1) begin
            return rnd[20] ? 255 : 0;
        end
        return int'(rnd[23:16]);
    endfunction

    function automatic int compute_cycle_limit();
        int total;
        total = 3 + 40;  // Reset plus drain margin.
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += ROW_COLS[i] * ((ROW_GAP[i] != 0) ? 2 : 1) + 1;
            if (ROW_WGT[i] != 0) begin
                total += NUM_TAPS + 8;
            end
        end
        return total;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("FAILED t=%0t %s: expected %0d, actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic write_weights(input int mode);
        logic [31:0] rnd;
        int          w;
        for (int t = 0; t < NUM_TAPS; t++) begin
            @(posedge clk);
            rnd = lcg_next();
            if (mode == 2) begin
                w = rnd[18] ? 127 : -128;
            end else begin
                w = int'($signed(rnd[23:16]));
            end
            weight_en   <= 1'b1;
            weight_idx  <= tap_idx_t'(t);
            weight_data <= weight_t'(w);
            model_wgt[t] = w;
        end
        @(posedge clk);
        weight_en <= 1'b0;
    endtask

    // One column strobe, plus the model update for that column.
    task automatic send_column(input int row, input bit first, input int stride,
                               input int pix_mode);
        int pix [KERNEL_DIM];
        int acc;
        @(posedge clk);
        for (int r = 0; r < KERNEL_DIM; r++) begin
            pix[r] = pick_pixel(pix_mode);
            col_pixels[r] <= pixel_t'(pix[r]);
        end
        col_valid  <= 1'b1;
        row_first  <= first;
        if (first) begin
            stride_sel <= (stride == 2) ? STRIDE_2 : STRIDE_1;
        end else begin
            stride_sel <= (stride == 2) ? STRIDE_1 : STRIDE_2;  // Later columns flip it.
        end
        for (int r = 0; r < KERNEL_DIM; r++) begin
            for (int c = 0; c < KERNEL_DIM - 1; c++) begin
                model_win[r][c] = first ? 0 : model_win[r][c+1];
            end
            model_win[r][KERNEL_DIM-1] = pix[r];
        end
        col_count = first ? 1 : col_count + 1;
        if (col_count >= 3 && (stride == 1 || (col_count - 3) % 2 == 0)) begin
            acc = 0;
            for (int r = 0; r < KERNEL_DIM; r++) begin
                for (int c = 0; c < KERNEL_DIM; c++) begin
                    acc += model_wgt[r*KERNEL_DIM + c] * model_win[r][c];
                end
            end
            exp_val_q.push_back(acc);
            exp_cyc_q.push_back(cyc + 4);  // Accepted next edge, result two edges on.
            exp_row_q.push_back(row);
        end
    endtask

    task automatic wait_for_drain();
        @(posedge clk);
        col_valid <= 1'b0;
        row_first <= 1'b0;
        while (exp_val_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_results();
        if (exp_val_q.size() != 0) begin
            $display("ERROR: %0d expected results never arrived", exp_val_q.size());
            errors++;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            check_value($sformatf("row %0d result count", i), ROW_EXP[i], got_count[i]);
        end
        $display("Checks done with %0d errors", errors);
    endtask

    // Output monitor, sampled away from the driving edge.
    initial begin
        cyc = 0;
        forever begin
            @(negedge clk);
            cyc++;
            if (ofmap_valid === 1'b1) begin
                if (exp_val_q.size() == 0) begin
                    $display("ERROR: ofmap_valid high at %0t with no result expected", $time);
                    errors++;
                end else begin
                    check_value("ofmap", exp_val_q.pop_front(), int'(ofmap));
                    check_value("ofmap_valid cycle", exp_cyc_q.pop_front(), cyc);
                    got_count[exp_row_q.pop_front()]++;
                end
            end
        end
    end

    initial begin
        #1;
        repeat (cycle_limit) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", cycle_limit);
        $display("Checks done with %0d errors", errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        lcg_state   = 32'd62324;
        errors      = 0;
        col_count   = 0;
        cycle_limit = compute_cycle_limit();
        rst         = 1'b1;
        weight_en   = 1'b0;
        weight_idx  = '0;
        weight_data = '0;
        stride_sel  = STRIDE_1;
        col_valid   = 1'b0;
        row_first   = 1'b0;
        col_pixels  = '0;
        for (int t = 0; t < NUM_TAPS; t++) begin
            model_wgt[t] = 0;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            got_count[i] = 0;
        end
        for (int r = 0; r < KERNEL_DIM; r++) begin
            for (int c = 0; c < KERNEL_DIM; c++) begin
                model_win[r][c] = 0;
            end
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (ROW_WGT[i] != 0) begin
                wait_for_drain();
                write_weights(ROW_WGT[i]);
            end
            for (int c = 0; c < ROW_COLS[i]; c++) begin
                send_column(i, c == 0, ROW_STRIDE[i], ROW_PIX[i]);
                if (ROW_GAP[i] != 0) begin
                    @(posedge clk);
                    col_valid <= 1'b0;  // Idle cycle between columns.
                end
            end
        end

        wait_for_drain();
        repeat (6) @(posedge clk);  // Room for any stray result.
        report_results();
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
conv_pkg.sv
psum_if.sv
weight_bank.sv
window_ctrl.sv
window_buffer.sv
pe_row.sv
mac_array.sv
ofmap_sum.sv
conv_top.sv
tb_conv_top.sv

// File: weight_bank.sv
`timescale 1ns/1ps

module weight_bank import conv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     weight_en,
    input  tap_idx_t                 weight_idx,
    input  weight_t                  weight_data,
    output weight_t [NUM_TAPS-1:0]   weights
);

    // One register per tap, row major.
    always_ff @(posedge clk) begin
        if (rst) begin
            weights <= '0;
        end else if (weight_en) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                if (weight_idx == tap_idx_t'(i)) begin
                    weights[i] <= weight_data;
                end
            end
        end
    end

    // Host must never address past the last tap.
    a_idx_range: assert property (@(posedge clk) disable iff (rst)
        weight_en |-> (weight_idx < tap_idx_t'(NUM_TAPS)));

endmodule

// File: window_buffer.sv
`timescale 1ns/1ps

module window_buffer import conv_pkg::*; (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     col_valid,
    input  logic                                     row_first,
    input  pixel_t [KERNEL_DIM-1:0]                  col_pixels,
    output pixel_t [KERNEL_DIM-1:0][KERNEL_DIM-1:0]  window
);

    // window[row][col], col 0 is the oldest column.
    always_ff @(posedge clk) begin
        if (rst) begin
            window <= '0;
        end else if (col_valid) begin
            for (int r = 0; r < KERNEL_DIM; r++) begin
                for (int c = 0; c < KERNEL_DIM - 1; c++) begin
                    // Older columns drop out on a new row.
                    window[r][c] <= row_first ? pixel_t'(0) : window[r][c+1];
                end
                window[r][KERNEL_DIM-1] <= col_pixels[r];  // Newest.
            end
        end
    end

endmodule

// File: window_ctrl.sv
`timescale 1ns/1ps

module window_ctrl import conv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         col_valid,
    input  logic         row_first,
    input  stride_mode_t stride_sel,
    output logic         fire
);

    row_state_t   state;
    stride_mode_t stride_q;  // Latched on the first column.
    logic         fill_cnt;  // Set once the second column is in.
    logic         phase;     // Skip flag for stride 2.

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ROW_IDLE;
            stride_q <= STRIDE_1;
            fill_cnt <= 1'b0;
            phase    <= 1'b0;
            fire     <= 1'b0;
        end else begin
            fire <= 1'b0;
            if (col_valid) begin
                if (row_first) begin
                    // Column count restarts at 1.
                    state    <= ROW_FILL;
                    stride_q <= stride_sel;
                    fill_cnt <= 1'b0;
                    phase    <= 1'b0;
                end else begin
                    case (state)
                        ROW_FILL: begin
                            if (fill_cnt) begin
                                state <= ROW_RUN;  // Third column, window full.
                                fire  <= 1'b1;
                                phase <= 1'b1;
                            end else begin
                                fill_cnt <= 1'b1;
                            end
                        end
                        ROW_RUN: begin
                            fire  <= (stride_q == STRIDE_1) || !phase;
                            phase <= ~phase;
                        end
                        default: begin
                            state <= ROW_IDLE;  // No open row.
                        end
                    endcase
                end
            end
        end
    end

    // A row can only open on a column flagged as first.
    a_idle_first: assert property (@(posedge clk) disable iff (rst)
        (col_valid && state == ROW_IDLE) |-> row_first);

endmodule
